// ==== all.f ====
+incdir+dv
source/isa_pkg.sv
source/ctrl_pkg.sv
source/instr_classify.sv
source/imm_ext.sv
source/reg_select.sv
source/id_ex_reg.sv
source/id_stage.sv
dv/tb_id_stage.sv

// ==== dv/tb_decode_model.svh ====
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

////////////////////////////////////////////////////////////
// Reference decode

function automatic ctrl_pkg::id_ctrl_t idle_ctrl();
	ctrl_pkg::id_ctrl_t c;
	c.alu_op      = ctrl_pkg::ALU_NONE;
	c.alu_src     = ctrl_pkg::SRC_NONE;
	c.imm         = 16'h0000;
	c.rd_a        = isa_pkg::NO_REG;
	c.rd_b        = isa_pkg::NO_REG;
	c.wr_reg      = isa_pkg::NO_REG;
	c.reg_write   = 1'b0;
	c.mem_read    = 1'b0;
	c.mem_write   = 1'b0;
	c.mem_to_reg  = 1'b0;
	c.is_branch   = 1'b0;
	c.is_jump     = 1'b0;
	c.branch_cond = ctrl_pkg::BR_ALWAYS;
	return c;
endfunction

// 8/4/5 signed, L signed 11, U unsigned 8, H shift amount, else zero
function automatic logic [15:0] imm_value(input logic [7:0] f, input logic [15:0] w);
	case (f)
		"8": return {{8{w[7]}}, w[7:0]};
		"4": return {{12{w[3]}}, w[3:0]};
		"5": return {{11{w[4]}}, w[4:0]};
		"L": return {{5{w[10]}}, w[10:0]};
		"U": return {8'h00, w[7:0]};
		"H": return (w[4:2] == 3'd0) ? 16'd8 : {13'd0, w[4:2]};
		default: return 16'h0000;
	endcase
endfunction

// X, Y, Z are the 3-bit fields; S, T, I, R the special registers
function automatic isa_pkg::reg_num_e reg_value(input logic [7:0] c, input logic [15:0] w);
	case (c)
		"X": return isa_pkg::reg_num_e'({1'b0, w[10:8]});
		"Y": return isa_pkg::reg_num_e'({1'b0, w[7:5]});
		"Z": return isa_pkg::reg_num_e'({1'b0, w[4:2]});
		"S": return isa_pkg::REG_SP;
		"T": return isa_pkg::REG_T;
		"I": return isa_pkg::REG_IH;
		"R": return isa_pkg::REG_RA;
		default: return isa_pkg::NO_REG;
	endcase
endfunction

function automatic ctrl_pkg::id_ctrl_t build_ctrl(
	input logic [15:0]       w,
	input ctrl_pkg::alu_op_e  op,
	input ctrl_pkg::alu_src_e src,
	input logic [7:0]        imm_f,
	input logic [23:0]       regs,   // rd_a, rd_b, wr_reg
	input logic [7:0]        flags   // w l s b z n j
);
	ctrl_pkg::id_ctrl_t c;
	c         = idle_ctrl();
	c.alu_op  = op;
	c.alu_src = src;
	c.imm     = imm_value(imm_f, w);
	c.rd_a    = reg_value(regs[23:16], w);
	c.rd_b    = reg_value(regs[15:8], w);
	c.wr_reg  = reg_value(regs[7:0], w);
	case (flags)
		"w": c.reg_write = 1'b1;
		"l": begin
			c.reg_write  = 1'b1;
			c.mem_read   = 1'b1;
			c.mem_to_reg = 1'b1;
		end
		"s": c.mem_write = 1'b1;
		"b": c.is_branch = 1'b1;
		"z": begin
			c.is_branch   = 1'b1;
			c.branch_cond = ctrl_pkg::BR_IF_ZERO;
		end
		"n": begin
			c.is_branch   = 1'b1;
			c.branch_cond = ctrl_pkg::BR_IF_NONZERO;
		end
		"j": c.is_jump = 1'b1;
		default: c.reg_write = 1'b0;
	endcase
	return c;
endfunction

function automatic ctrl_pkg::id_ctrl_t expected_ctrl(input logic [15:0] w);
	casez (w)
		16'b01001_???????????:
			return build_ctrl(w, ctrl_pkg::ALU_ADD, ctrl_pkg::SRC_REG_IMM, "8", "X-X", "w");
		16'b01000_???????????:
			return build_ctrl(w, ctrl_pkg::ALU_ADD, ctrl_pkg::SRC_REG_IMM, "4", "X-Y", "w");
		16'b01100_011_????????:
			return build_ctrl(w, ctrl_pkg::ALU_ADD, ctrl_pkg::SRC_REG_IMM, "8", "S-S", "w");
		16'b11100_?????????_01:
			return build_ctrl(w, ctrl_pkg::ALU_ADD, ctrl_pkg::SRC_REG_REG, "0", "XYZ", "w");
		16'b11100_?????????_11:
			return build_ctrl(w, ctrl_pkg::ALU_SUB, ctrl_pkg::SRC_REG_REG, "0", "XYZ", "w");
		16'b11101_??????_01100:
			return build_ctrl(w, ctrl_pkg::ALU_AND, ctrl_pkg::SRC_REG_REG, "0", "XYX", "w");
		16'b11101_??????_01101:
			return build_ctrl(w, ctrl_pkg::ALU_OR, ctrl_pkg::SRC_REG_REG, "0", "XYX", "w");
		16'b11101_??????_01010:
			return build_ctrl(w, ctrl_pkg::ALU_EQUAL, ctrl_pkg::SRC_REG_REG, "0", "XYT", "w");
		16'b01110_???????????:
			return build_ctrl(w, ctrl_pkg::ALU_EQUAL, ctrl_pkg::SRC_REG_IMM, "8", "X-T", "w");
		16'b11101_??????_00010:
			return build_ctrl(w, ctrl_pkg::ALU_LESS, ctrl_pkg::SRC_REG_REG, "0", "XYT", "w");
		16'b11101_??????_00111: // Operands swapped
			return build_ctrl(w, ctrl_pkg::ALU_SRA, ctrl_pkg::SRC_REG_REG, "0", "YXY", "w");
		16'b00110_?????????_00:
			return build_ctrl(w, ctrl_pkg::ALU_SLL, ctrl_pkg::SRC_REG_IMM, "H", "Y-X", "w");
		16'b00110_?????????_11:
			return build_ctrl(w, ctrl_pkg::ALU_SRA, ctrl_pkg::SRC_REG_IMM, "H", "Y-X", "w");
		16'b01101_???????????:
			return build_ctrl(w, ctrl_pkg::ALU_MOVE, ctrl_pkg::SRC_IMM_ONLY, "U", "--X", "w");
		16'b01100_100_????????:
			return build_ctrl(w, ctrl_pkg::ALU_MOVE, ctrl_pkg::SRC_REG_ONLY, "0", "Y-S", "w");
		16'b11110_??????????_0:
			return build_ctrl(w, ctrl_pkg::ALU_MOVE, ctrl_pkg::SRC_REG_ONLY, "0", "I-X", "w");
		16'b11110_??????????_1:
			return build_ctrl(w, ctrl_pkg::ALU_MOVE, ctrl_pkg::SRC_REG_ONLY, "0", "X-I", "w");
		16'b10011_???????????:
			return build_ctrl(w, ctrl_pkg::ALU_ADD, ctrl_pkg::SRC_REG_IMM, "5", "X-Y", "l");
		16'b10010_???????????:
			return build_ctrl(w, ctrl_pkg::ALU_ADD, ctrl_pkg::SRC_REG_IMM, "8", "S-X", "l");
		16'b11011_???????????:
			return build_ctrl(w, ctrl_pkg::ALU_ADD, ctrl_pkg::SRC_REG_IMM, "5", "XY-", "s");
		16'b11010_???????????:
			return build_ctrl(w, ctrl_pkg::ALU_ADD, ctrl_pkg::SRC_REG_IMM, "8", "SX-", "s");
		16'b01100_010_????????:
			return build_ctrl(w, ctrl_pkg::ALU_ADD, ctrl_pkg::SRC_REG_IMM, "8", "SR-", "s");
		16'b00010_???????????:
			return build_ctrl(w, ctrl_pkg::ALU_NONE, ctrl_pkg::SRC_NONE, "L", "---", "b");
		16'b00100_???????????:
			return build_ctrl(w, ctrl_pkg::ALU_NONE, ctrl_pkg::SRC_NONE, "8", "X--", "z");
		16'b00101_???????????:
			return build_ctrl(w, ctrl_pkg::ALU_NONE, ctrl_pkg::SRC_NONE, "8", "X--", "n");
		16'b01100_000_????????:
			return build_ctrl(w, ctrl_pkg::ALU_NONE, ctrl_pkg::SRC_NONE, "8", "T--", "z");
		16'b01100_001_????????:
			return build_ctrl(w, ctrl_pkg::ALU_NONE, ctrl_pkg::SRC_NONE, "8", "T--", "n");
		16'b11101_???_000_00000:
			return build_ctrl(w, ctrl_pkg::ALU_NONE, ctrl_pkg::SRC_NONE, "0", "X--", "j");
		default:
			return idle_ctrl(); // NOP and anything unknown
	endcase
endfunction

////////////////////////////////////////////////////////////
// Instruction generator

// Fixed bits in the upper half, random field mask in the lower half
function automatic logic [31:0] template_word(input logic [4:0] idx);
	case (idx)
		5'd0:  return 32'h4800_07FF; // ADDIU
		5'd1:  return 32'h4000_07EF; // ADDIU3
		5'd2:  return 32'h6300_00FF; // ADDSP
		5'd3:  return 32'hE001_07FC; // ADDU
		5'd4:  return 32'hE003_07FC; // SUBU
		5'd5:  return 32'hE80C_07E0; // AND
		5'd6:  return 32'hE80D_07E0; // OR
		5'd7:  return 32'hE80A_07E0; // CMP
		5'd8:  return 32'h7000_07FF; // CMPI
		5'd9:  return 32'hE802_07E0; // SLT
		5'd10: return 32'hE807_07E0; // SRAV
		5'd11: return 32'h3000_07FC; // SLL
		5'd12: return 32'h3003_07FC; // SRA
		5'd13: return 32'h6800_07FF; // LI
		5'd14: return 32'h6400_00E0; // MTSP
		5'd15: return 32'hF000_0700; // MFIH
		5'd16: return 32'hF001_0700; // MTIH
		5'd17: return 32'h9800_07FF; // LW
		5'd18: return 32'h9000_07FF; // LW_SP
		5'd19: return 32'hD800_07FF; // SW
		5'd20: return 32'hD000_07FF; // SW_SP
		5'd21: return 32'h6200_00FF; // SW_RS
		5'd22: return 32'h1000_07FF; // B
		5'd23: return 32'h2000_07FF; // BEQZ
		5'd24: return 32'h2800_07FF; // BNEZ
		5'd25: return 32'h6000_00FF; // BTEQZ
		5'd26: return 32'h6100_00FF; // BTNEZ
		5'd27: return 32'hE800_0700; // JR
		5'd28: return 32'hF800_000F; // INT, dropped
		5'd29: return 32'hE840_0700; // MFPC, dropped
		default: return 32'h0800_0000; // NOP
	endcase
endfunction

function automatic logic [15:0] gen_instr(
	input logic [15:0] pick,
	input logic [15:0] which,
	input logic [15:0] bits
);
	logic [31:0] t;
	if (pick % 16'd10 == 16'd0) begin
		return bits; // Raw word
	end
	t = template_word(5'(which % 16'd31));
	return t[31:16] | (bits & t[15:0]);
endfunction

`endif

// ==== dv/tb_id_stage.sv ====
`default_nettype none

module tb_id_stage;

	localparam int N_XFER     = 2000;
	localparam int MAX_CYCLES = 4 * N_XFER; // About twice the expected run

	logic                        clk;
	logic                        arst_n;
	logic [isa_pkg::INSTR_W-1:0] instr;
	logic                        in_valid;
	logic                        in_ready;
	logic                        out_valid;
	logic                        out_ready;
	ctrl_pkg::id_ctrl_t          ctrl;

	ctrl_pkg::id_ctrl_t exp_q[$]; // Words held in the ID/EX register
	logic [31:0]        seed;
	int                 cycles;
	int                 n_in;
	int                 n_out;
	logic               in_fire;

	`include "tb_decode_model.svh"

	id_stage DUT (
		.clk       (clk),
		.arst_n    (arst_n),
		.instr     (instr),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.ctrl      (ctrl)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [15:0] rand16();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed[31:16]; // Upper bits are the better ones
	endfunction

	////////////////////////////////////////////////////////////
	// Checks

	task automatic check_eq(
		input string       name,
		input logic [31:0] got,
		input logic [31:0] exp
	);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic compare_ctrl(input ctrl_pkg::id_ctrl_t got, input ctrl_pkg::id_ctrl_t exp);
		check_eq("ctrl.alu_op", 32'(got.alu_op), 32'(exp.alu_op));
		check_eq("ctrl.alu_src", 32'(got.alu_src), 32'(exp.alu_src));
		check_eq("ctrl.imm", 32'(got.imm), 32'(exp.imm));
		check_eq("ctrl.rd_a", 32'(got.rd_a), 32'(exp.rd_a));
		check_eq("ctrl.rd_b", 32'(got.rd_b), 32'(exp.rd_b));
		check_eq("ctrl.wr_reg", 32'(got.wr_reg), 32'(exp.wr_reg));
		check_eq("ctrl.reg_write", 32'(got.reg_write), 32'(exp.reg_write));
		check_eq("ctrl.mem_read", 32'(got.mem_read), 32'(exp.mem_read));
		check_eq("ctrl.mem_write", 32'(got.mem_write), 32'(exp.mem_write));
		check_eq("ctrl.mem_to_reg", 32'(got.mem_to_reg), 32'(exp.mem_to_reg));
		check_eq("ctrl.is_branch", 32'(got.is_branch), 32'(exp.is_branch));
		check_eq("ctrl.is_jump", 32'(got.is_jump), 32'(exp.is_jump));
		check_eq("ctrl.branch_cond", 32'(got.branch_cond), 32'(exp.branch_cond));
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus and scoreboard

	task automatic drive_inputs();
		logic [15:0] r0;
		logic [15:0] r1;
		logic [15:0] r2;
		if (!(in_valid && !in_fire)) begin // A pending word stays put
			r0       = rand16();
			r1       = rand16();
			r2       = rand16();
			in_valid = (n_in < N_XFER) && ((rand16() % 16'd100) < 16'd75);
			instr    = gen_instr(r0, r1, r2);
		end
		out_ready = (rand16() % 16'd100) < 16'd70;
	endtask

	// Runs mid-cycle, decides what transfers at the next rising edge
	task automatic score_cycle();
		logic exp_valid;
		exp_valid = exp_q.size() != 0;
		check_eq("out_valid", 32'(out_valid), 32'(exp_valid));
		check_eq("in_ready", 32'(in_ready), 32'(!(exp_valid && !out_ready)));
		if (exp_valid) begin
			compare_ctrl(ctrl, exp_q[0]); // Also covers hold under stall
			if (out_ready) begin
				exp_q.delete(0);
				n_out++;
			end
		end
		in_fire = in_valid && in_ready;
		if (in_fire) begin
			exp_q.push_back(expected_ctrl(instr));
			n_in++;
		end
	endtask

	initial begin
		seed      = 32'hf3e0;
		arst_n    = 1'b0;
		instr     = '0;
		in_valid  = 1'b0;
		out_ready = 1'b0;
		n_in      = 0;
		n_out     = 0;
		in_fire   = 1'b0;

		repeat (7) @(posedge clk);
		@(negedge clk);
		check_eq("out_valid", 32'(out_valid), 32'd0);
		compare_ctrl(ctrl, idle_ctrl());
		@(posedge clk);
		#2;
		arst_n = 1'b1;

		// Idle after reset
		repeat (4) begin
			@(negedge clk);
			check_eq("out_valid", 32'(out_valid), 32'd0);
			check_eq("in_ready", 32'(in_ready), 32'd1);
			compare_ctrl(ctrl, idle_ctrl());
		end

		while (n_out < N_XFER) begin
			@(posedge clk);
			#2;
			drive_inputs();
			@(negedge clk);
			score_cycle();
		end

		$display("%0d decoded words checked in %0d cycles", n_out, cycles);
		$display("ALL CHECKS PASSED");
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, %0d of %0d words out", cycles, n_out, N_XFER);
		$display("CHECKS FAILED");
		$fatal(1, "run did not finish in time");
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_id_stage -f all.f -o sim_id_stage

./obj_dir/sim_id_stage | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

// ==== source/ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

	typedef enum logic [3:0] {
		ALU_ADD   = 4'b0000,
		ALU_AND   = 4'b0001,
		ALU_OR    = 4'b0010,
		ALU_SLL   = 4'b0011,
		ALU_SRL   = 4'b0100,
		ALU_SRA   = 4'b0101,
		ALU_SUB   = 4'b0110,
		ALU_EQUAL = 4'b0111,
		ALU_LESS  = 4'b1000,
		ALU_MOVE  = 4'b1001,
		ALU_NONE  = 4'b1111
	} alu_op_e;

	typedef enum logic [2:0] {
		SRC_NONE     = 3'b000,
		SRC_REG_REG  = 3'b001,
		SRC_REG_IMM  = 3'b010,
		SRC_REG_ONLY = 3'b011,
		SRC_IMM_ONLY = 3'b100
	} alu_src_e;

	typedef enum logic [1:0] {
		BR_ALWAYS     = 2'b00,
		BR_IF_ZERO    = 2'b01,
		BR_IF_NONZERO = 2'b10
	} branch_cond_e;

	typedef enum logic [2:0] {
		IMM_SIMM8, IMM_SIMM4, IMM_SIMM5, IMM_SIMM11,
		IMM_ZIMM8, IMM_SHAMT3, IMM_ZERO
	} imm_fmt_e;

	////////////////////////////////////////////////////////////
	typedef struct packed {
		alu_op_e                      alu_op;
		alu_src_e                     alu_src;
		logic [isa_pkg::DATA_W-1:0]   imm;
		isa_pkg::reg_num_e            rd_a;
		isa_pkg::reg_num_e            rd_b;
		isa_pkg::reg_num_e            wr_reg;
		logic                         reg_write;
		logic                         mem_read;
		logic                         mem_write;
		logic                         mem_to_reg; // Write back from memory
		logic                         is_branch;
		logic                         is_jump;
		branch_cond_e                 branch_cond;
	} id_ctrl_t;

	localparam id_ctrl_t CTRL_IDLE = '{
		alu_op:      ALU_NONE,
		alu_src:     SRC_NONE,
		imm:         '0,
		rd_a:        isa_pkg::NO_REG,
		rd_b:        isa_pkg::NO_REG,
		wr_reg:      isa_pkg::NO_REG,
		reg_write:   1'b0,
		mem_read:    1'b0,
		mem_write:   1'b0,
		mem_to_reg:  1'b0,
		is_branch:   1'b0,
		is_jump:     1'b0,
		branch_cond: BR_ALWAYS
	};

endpackage

`default_nettype wire

// ==== source/id_ex_reg.sv ====
`default_nettype none

module id_ex_reg (
	input  wire                 clk,
	input  wire                 arst_n,
	input  wire                 in_valid,
	output logic                in_ready,
	input  wire  ctrl_pkg::id_ctrl_t next,
	output logic                out_valid,
	input  wire                 out_ready,
	output ctrl_pkg::id_ctrl_t  ctrl
);

	// Room when empty or the held word leaves this cycle
	assign in_ready = !out_valid || out_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			ctrl      <= ctrl_pkg::CTRL_IDLE;
		end else begin
			if (in_ready) begin
				out_valid <= in_valid;
			end
			if (in_valid && in_ready) begin
				ctrl <= next;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Checks

	a_stall_hold: assert property (
		@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(ctrl)
	) else $error("ctrl changed under back-pressure");

	a_mem_excl: assert property (
		@(posedge clk) disable iff (!arst_n)
		out_valid |-> !(ctrl.mem_read && ctrl.mem_write)
	) else $error("load and store flagged together");

	a_wb_target: assert property (
		@(posedge clk) disable iff (!arst_n)
		out_valid && ctrl.reg_write |-> ctrl.wr_reg != isa_pkg::NO_REG
	) else $error("write-back without a target register");

endmodule

`default_nettype wire

// ==== source/id_stage.sv ====
`default_nettype none

module id_stage (
	input  wire                         clk,
	input  wire                         arst_n,
	input  wire  [isa_pkg::INSTR_W-1:0] instr,
	input  wire                         in_valid,
	output logic                        in_ready,
	output logic                        out_valid,
	input  wire                         out_ready,
	output ctrl_pkg::id_ctrl_t          ctrl
);

	isa_pkg::instr_kind_e         kind;
	ctrl_pkg::alu_op_e            alu_op;
	ctrl_pkg::alu_src_e           alu_src;
	ctrl_pkg::imm_fmt_e           imm_fmt;
	ctrl_pkg::branch_cond_e       branch_cond;
	logic                         reg_write;
	logic                         mem_read;
	logic                         mem_write;
	logic                         mem_to_reg;
	logic                         is_branch;
	logic                         is_jump;
	logic [isa_pkg::DATA_W-1:0]   imm;
	isa_pkg::reg_num_e            rd_a;
	isa_pkg::reg_num_e            rd_b;
	isa_pkg::reg_num_e            wr_reg;
	ctrl_pkg::id_ctrl_t           next_ctrl;

	////////////////////////////////////////////////////////////
	// Combinational decode
	instr_classify u_classify (
		.instr       (instr),
		.kind        (kind),
		.alu_op      (alu_op),
		.alu_src     (alu_src),
		.imm_fmt     (imm_fmt),
		.reg_write   (reg_write),
		.mem_read    (mem_read),
		.mem_write   (mem_write),
		.mem_to_reg  (mem_to_reg),
		.is_branch   (is_branch),
		.is_jump     (is_jump),
		.branch_cond (branch_cond)
	);

	imm_ext u_imm_ext (
		.instr   (instr),
		.imm_fmt (imm_fmt),
		.imm     (imm)
	);

	reg_select u_reg_select (
		.instr  (instr),
		.kind   (kind),
		.rd_a   (rd_a),
		.rd_b   (rd_b),
		.wr_reg (wr_reg)
	);

	assign next_ctrl = '{
		alu_op:      alu_op,
		alu_src:     alu_src,
		imm:         imm,
		rd_a:        rd_a,
		rd_b:        rd_b,
		wr_reg:      wr_reg,
		reg_write:   reg_write,
		mem_read:    mem_read,
		mem_write:   mem_write,
		mem_to_reg:  mem_to_reg,
		is_branch:   is_branch,
		is_jump:     is_jump,
		branch_cond: branch_cond
	};

	////////////////////////////////////////////////////////////
	// ID/EX register
	id_ex_reg u_id_ex (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.next      (next_ctrl),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.ctrl      (ctrl)
	);

endmodule

`default_nettype wire

// ==== source/imm_ext.sv ====
`default_nettype none

module imm_ext (
	input  wire  [isa_pkg::INSTR_W-1:0] instr,
	input  wire  ctrl_pkg::imm_fmt_e    imm_fmt,
	output logic [isa_pkg::DATA_W-1:0]  imm
);

	localparam int W = isa_pkg::DATA_W;

	logic [2:0] shamt;

	assign shamt = instr[4:2];

	always_comb begin
		case (imm_fmt)
			ctrl_pkg::IMM_SIMM8: begin
				imm = {{(W-8){instr[7]}}, instr[7:0]};
			end
			ctrl_pkg::IMM_SIMM4: begin
				imm = {{(W-4){instr[3]}}, instr[3:0]}; // ADDIU3
			end
			ctrl_pkg::IMM_SIMM5: begin
				imm = {{(W-5){instr[4]}}, instr[4:0]}; // LW/SW offset
			end
			ctrl_pkg::IMM_SIMM11: begin
				imm = {{(W-11){instr[10]}}, instr[10:0]};
			end
			ctrl_pkg::IMM_ZIMM8: begin
				imm = {{(W-8){1'b0}}, instr[7:0]};
			end
			ctrl_pkg::IMM_SHAMT3: begin
				if (shamt == 3'd0) begin
					imm = W'(8); // Zero encodes a shift of 8
				end else begin
					imm = {{(W-3){1'b0}}, shamt};
				end
			end
			default: begin
				imm = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== source/instr_classify.sv ====
`default_nettype none

module instr_classify (
	input  wire  [isa_pkg::INSTR_W-1:0] instr,
	output isa_pkg::instr_kind_e        kind,
	output ctrl_pkg::alu_op_e           alu_op,
	output ctrl_pkg::alu_src_e          alu_src,
	output ctrl_pkg::imm_fmt_e          imm_fmt,
	output logic                        reg_write,
	output logic                        mem_read,
	output logic                        mem_write,
	output logic                        mem_to_reg,
	output logic                        is_branch,
	output logic                        is_jump,
	output ctrl_pkg::branch_cond_e      branch_cond
);

	isa_pkg::major_op_e op;

	assign op = isa_pkg::major_op_e'(instr[15:11]);

	////////////////////////////////////////////////////////////
	// Instruction identification
	always_comb begin
		kind = isa_pkg::K_NOP; // Unknown words, INT and MFPC
		case (op)
			isa_pkg::OP_ADDIU:  kind = isa_pkg::K_ADDIU;
			isa_pkg::OP_ADDIU3: kind = isa_pkg::K_ADDIU3;
			isa_pkg::OP_B:      kind = isa_pkg::K_B;
			isa_pkg::OP_BEQZ:   kind = isa_pkg::K_BEQZ;
			isa_pkg::OP_BNEZ:   kind = isa_pkg::K_BNEZ;
			isa_pkg::OP_LI:     kind = isa_pkg::K_LI;
			isa_pkg::OP_CMPI:   kind = isa_pkg::K_CMPI;
			isa_pkg::OP_LW:     kind = isa_pkg::K_LW;
			isa_pkg::OP_LW_SP:  kind = isa_pkg::K_LW_SP;
			isa_pkg::OP_SW:     kind = isa_pkg::K_SW;
			isa_pkg::OP_SW_SP:  kind = isa_pkg::K_SW_SP;
			isa_pkg::OP_NOP:    kind = isa_pkg::K_NOP;
			isa_pkg::OP_SP_GRP: begin
				case (instr[10:8])
					isa_pkg::FN_BTEQZ: kind = isa_pkg::K_BTEQZ;
					isa_pkg::FN_BTNEZ: kind = isa_pkg::K_BTNEZ;
					isa_pkg::FN_SW_RS: kind = isa_pkg::K_SW_RS;
					isa_pkg::FN_ADDSP: kind = isa_pkg::K_ADDSP;
					isa_pkg::FN_MTSP:  kind = isa_pkg::K_MTSP;
					default:           kind = isa_pkg::K_NOP;
				endcase
			end
			isa_pkg::OP_RRR: begin
				case (instr[1:0])
					isa_pkg::FN_ADDU: kind = isa_pkg::K_ADDU;
					isa_pkg::FN_SUBU: kind = isa_pkg::K_SUBU;
					default:          kind = isa_pkg::K_NOP;
				endcase
			end
			isa_pkg::OP_SHIFT: begin
				case (instr[1:0])
					isa_pkg::FN_SLL: kind = isa_pkg::K_SLL;
					isa_pkg::FN_SRA: kind = isa_pkg::K_SRA;
					default:         kind = isa_pkg::K_NOP;
				endcase
			end
			isa_pkg::OP_ALU_RR: begin
				case (instr[4:0])
					isa_pkg::FN_AND:    kind = isa_pkg::K_AND;
					isa_pkg::FN_OR:     kind = isa_pkg::K_OR;
					isa_pkg::FN_CMP:    kind = isa_pkg::K_CMP;
					isa_pkg::FN_SLT:    kind = isa_pkg::K_SLT;
					isa_pkg::FN_SRAV:   kind = isa_pkg::K_SRAV;
					isa_pkg::FN_JR_GRP: begin
						if (instr[7:5] == isa_pkg::FN_JR) begin
							kind = isa_pkg::K_JR;
						end
					end
					default:            kind = isa_pkg::K_NOP;
				endcase
			end
			isa_pkg::OP_IH: kind = (instr[0] == isa_pkg::FN_MTIH) ? isa_pkg::K_MTIH
				: isa_pkg::K_MFIH;
			default: kind = isa_pkg::K_NOP;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Per-kind controls
	always_comb begin
		case (kind)
			isa_pkg::K_ADDIU, isa_pkg::K_ADDIU3, isa_pkg::K_ADDSP, isa_pkg::K_ADDU,
			isa_pkg::K_LW, isa_pkg::K_LW_SP, isa_pkg::K_SW, isa_pkg::K_SW_SP,
			isa_pkg::K_SW_RS:                     alu_op = ctrl_pkg::ALU_ADD; // Also address add
			isa_pkg::K_SUBU:                      alu_op = ctrl_pkg::ALU_SUB;
			isa_pkg::K_AND:                       alu_op = ctrl_pkg::ALU_AND;
			isa_pkg::K_OR:                        alu_op = ctrl_pkg::ALU_OR;
			isa_pkg::K_CMP, isa_pkg::K_CMPI:      alu_op = ctrl_pkg::ALU_EQUAL;
			isa_pkg::K_SLT:                       alu_op = ctrl_pkg::ALU_LESS;
			isa_pkg::K_SRAV, isa_pkg::K_SRA:      alu_op = ctrl_pkg::ALU_SRA;
			isa_pkg::K_SLL:                       alu_op = ctrl_pkg::ALU_SLL;
			isa_pkg::K_LI, isa_pkg::K_MTSP,
			isa_pkg::K_MFIH, isa_pkg::K_MTIH:     alu_op = ctrl_pkg::ALU_MOVE;
			default:                              alu_op = ctrl_pkg::ALU_NONE;
		endcase

		case (kind)
			isa_pkg::K_ADDU, isa_pkg::K_SUBU, isa_pkg::K_AND, isa_pkg::K_OR,
			isa_pkg::K_CMP, isa_pkg::K_SLT, isa_pkg::K_SRAV:
				alu_src = ctrl_pkg::SRC_REG_REG;
			isa_pkg::K_ADDIU, isa_pkg::K_ADDIU3, isa_pkg::K_ADDSP, isa_pkg::K_CMPI,
			isa_pkg::K_SLL, isa_pkg::K_SRA, isa_pkg::K_LW, isa_pkg::K_LW_SP,
			isa_pkg::K_SW, isa_pkg::K_SW_SP, isa_pkg::K_SW_RS:
				alu_src = ctrl_pkg::SRC_REG_IMM;
			isa_pkg::K_MTSP, isa_pkg::K_MFIH, isa_pkg::K_MTIH:
				alu_src = ctrl_pkg::SRC_REG_ONLY;
			isa_pkg::K_LI: alu_src = ctrl_pkg::SRC_IMM_ONLY;
			default:       alu_src = ctrl_pkg::SRC_NONE;
		endcase

		case (kind)
			isa_pkg::K_ADDIU, isa_pkg::K_ADDSP, isa_pkg::K_CMPI, isa_pkg::K_LW_SP,
			isa_pkg::K_SW_SP, isa_pkg::K_SW_RS, isa_pkg::K_BEQZ, isa_pkg::K_BNEZ,
			isa_pkg::K_BTEQZ, isa_pkg::K_BTNEZ:
				imm_fmt = ctrl_pkg::IMM_SIMM8;
			isa_pkg::K_ADDIU3:            imm_fmt = ctrl_pkg::IMM_SIMM4;
			isa_pkg::K_LW, isa_pkg::K_SW: imm_fmt = ctrl_pkg::IMM_SIMM5;
			isa_pkg::K_B:                 imm_fmt = ctrl_pkg::IMM_SIMM11;
			isa_pkg::K_LI:                imm_fmt = ctrl_pkg::IMM_ZIMM8;
			isa_pkg::K_SLL, isa_pkg::K_SRA: imm_fmt = ctrl_pkg::IMM_SHAMT3;
			default:                      imm_fmt = ctrl_pkg::IMM_ZERO;
		endcase

		case (kind)
			isa_pkg::K_BEQZ, isa_pkg::K_BTEQZ: branch_cond = ctrl_pkg::BR_IF_ZERO;
			isa_pkg::K_BNEZ, isa_pkg::K_BTNEZ: branch_cond = ctrl_pkg::BR_IF_NONZERO;
			default:                           branch_cond = ctrl_pkg::BR_ALWAYS;
		endcase
	end

	assign mem_read   = kind inside {isa_pkg::K_LW, isa_pkg::K_LW_SP};
	assign mem_to_reg = mem_read;
	assign mem_write  = kind inside {isa_pkg::K_SW, isa_pkg::K_SW_SP, isa_pkg::K_SW_RS};
	assign is_branch  = kind inside {isa_pkg::K_B, isa_pkg::K_BEQZ, isa_pkg::K_BNEZ,
		isa_pkg::K_BTEQZ, isa_pkg::K_BTNEZ};
	assign is_jump    = (kind == isa_pkg::K_JR);

	// Everything else writes a register
	assign reg_write = !(is_branch || is_jump || mem_write || kind == isa_pkg::K_NOP);

endmodule

`default_nettype wire

// ==== source/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

	localparam int INSTR_W = 16;
	localparam int REG_W   = 4;
	localparam int DATA_W  = 16;

	////////////////////////////////////////////////////////////
	// Major opcodes in bits 15 to 11
	typedef enum logic [4:0] {
		OP_NOP    = 5'b00001,
		OP_B      = 5'b00010,
		OP_BEQZ   = 5'b00100,
		OP_BNEZ   = 5'b00101,
		OP_SHIFT  = 5'b00110, // SLL, SRA
		OP_ADDIU3 = 5'b01000,
		OP_ADDIU  = 5'b01001,
		OP_SP_GRP = 5'b01100, // ADDSP, BTEQZ, BTNEZ, MTSP, SW_RS
		OP_LI     = 5'b01101,
		OP_CMPI   = 5'b01110,
		OP_LW_SP  = 5'b10010,
		OP_LW     = 5'b10011,
		OP_SW_SP  = 5'b11010,
		OP_SW     = 5'b11011,
		OP_RRR    = 5'b11100, // ADDU, SUBU
		OP_ALU_RR = 5'b11101,
		OP_IH     = 5'b11110  // MFIH, MTIH
	} major_op_e;

	// Sub-functions of OP_SP_GRP, bits 10 to 8
	localparam logic [2:0] FN_BTEQZ = 3'b000;
	localparam logic [2:0] FN_BTNEZ = 3'b001;
	localparam logic [2:0] FN_SW_RS = 3'b010;
	localparam logic [2:0] FN_ADDSP = 3'b011;
	localparam logic [2:0] FN_MTSP  = 3'b100;

	// OP_RRR and OP_SHIFT, bits 1 to 0
	localparam logic [1:0] FN_ADDU = 2'b01;
	localparam logic [1:0] FN_SUBU = 2'b11;
	localparam logic [1:0] FN_SLL  = 2'b00;
	localparam logic [1:0] FN_SRA  = 2'b11;

	// OP_ALU_RR, bits 4 to 0
	localparam logic [4:0] FN_SLT    = 5'b00010;
	localparam logic [4:0] FN_SRAV   = 5'b00111;
	localparam logic [4:0] FN_CMP    = 5'b01010;
	localparam logic [4:0] FN_AND    = 5'b01100;
	localparam logic [4:0] FN_OR     = 5'b01101;
	localparam logic [4:0] FN_JR_GRP = 5'b00000;
	localparam logic [2:0] FN_JR     = 3'b000; // Bits 7 to 5 inside FN_JR_GRP

	// OP_IH, bit 0
	localparam logic FN_MFIH = 1'b0;
	localparam logic FN_MTIH = 1'b1;

	////////////////////////////////////////////////////////////
	typedef enum logic [REG_W-1:0] {
		REG_R0 = 4'd0,
		REG_R1 = 4'd1,
		REG_R2 = 4'd2,
		REG_R3 = 4'd3,
		REG_R4 = 4'd4,
		REG_R5 = 4'd5,
		REG_R6 = 4'd6,
		REG_R7 = 4'd7,
		REG_SP = 4'd8,
		REG_T  = 4'd9,
		REG_IH = 4'd10,
		REG_RA = 4'd11,
		NO_REG = 4'd15  // Port unused
	} reg_num_e;

	typedef enum logic [4:0] {
		K_ADDIU, K_ADDIU3, K_ADDSP, K_ADDU, K_SUBU,
		K_AND, K_OR, K_CMP, K_CMPI, K_SLT,
		K_SRAV, K_SLL, K_SRA, K_LI,
		K_MTSP, K_MFIH, K_MTIH,
		K_LW, K_LW_SP, K_SW, K_SW_SP, K_SW_RS,
		K_B, K_BEQZ, K_BNEZ, K_BTEQZ, K_BTNEZ, K_JR,
		K_NOP
	} instr_kind_e;

endpackage

`default_nettype wire

// ==== source/reg_select.sv ====
`default_nettype none

module reg_select (
	input  wire  [isa_pkg::INSTR_W-1:0] instr,
	input  wire  isa_pkg::instr_kind_e  kind,
	output isa_pkg::reg_num_e           rd_a,
	output isa_pkg::reg_num_e           rd_b,
	output isa_pkg::reg_num_e           wr_reg
);

	isa_pkg::reg_num_e rx;
	isa_pkg::reg_num_e ry;
	isa_pkg::reg_num_e rz;

	// General registers sit below SP
	assign rx = isa_pkg::reg_num_e'({1'b0, instr[10:8]});
	assign ry = isa_pkg::reg_num_e'({1'b0, instr[7:5]});
	assign rz = isa_pkg::reg_num_e'({1'b0, instr[4:2]});

	always_comb begin
		case (kind)
			isa_pkg::K_ADDIU, isa_pkg::K_ADDIU3, isa_pkg::K_ADDU, isa_pkg::K_SUBU,
			isa_pkg::K_AND, isa_pkg::K_OR, isa_pkg::K_CMP, isa_pkg::K_SLT,
			isa_pkg::K_CMPI, isa_pkg::K_BEQZ, isa_pkg::K_BNEZ, isa_pkg::K_JR,
			isa_pkg::K_LW, isa_pkg::K_SW, isa_pkg::K_MTIH:
				rd_a = rx;
			isa_pkg::K_MTSP, isa_pkg::K_SLL, isa_pkg::K_SRA,
			isa_pkg::K_SRAV:
				rd_a = ry; // SRAV takes its operands swapped
			isa_pkg::K_ADDSP, isa_pkg::K_LW_SP, isa_pkg::K_SW_SP, isa_pkg::K_SW_RS:
				rd_a = isa_pkg::REG_SP;
			isa_pkg::K_BTEQZ, isa_pkg::K_BTNEZ:
				rd_a = isa_pkg::REG_T;
			isa_pkg::K_MFIH:
				rd_a = isa_pkg::REG_IH;
			default:
				rd_a = isa_pkg::NO_REG;
		endcase

		case (kind)
			isa_pkg::K_ADDU, isa_pkg::K_SUBU, isa_pkg::K_AND, isa_pkg::K_OR,
			isa_pkg::K_CMP, isa_pkg::K_SLT, isa_pkg::K_SW:
				rd_b = ry;
			isa_pkg::K_SRAV, isa_pkg::K_SW_SP:
				rd_b = rx; // Store data for SW_SP
			isa_pkg::K_SW_RS:
				rd_b = isa_pkg::REG_RA;
			default:
				rd_b = isa_pkg::NO_REG;
		endcase

		case (kind)
			isa_pkg::K_ADDIU, isa_pkg::K_AND, isa_pkg::K_OR, isa_pkg::K_LI,
			isa_pkg::K_LW_SP, isa_pkg::K_MFIH, isa_pkg::K_SLL, isa_pkg::K_SRA:
				wr_reg = rx;
			isa_pkg::K_ADDIU3, isa_pkg::K_LW, isa_pkg::K_SRAV:
				wr_reg = ry;
			isa_pkg::K_ADDU, isa_pkg::K_SUBU:
				wr_reg = rz;
			isa_pkg::K_ADDSP, isa_pkg::K_MTSP:
				wr_reg = isa_pkg::REG_SP;
			isa_pkg::K_CMP, isa_pkg::K_SLT, isa_pkg::K_CMPI:
				wr_reg = isa_pkg::REG_T; // Compare result
			isa_pkg::K_MTIH:
				wr_reg = isa_pkg::REG_IH;
			default:
				wr_reg = isa_pkg::NO_REG;
		endcase
	end

endmodule

`default_nettype wire
